// ==== lb_defs.svh ====
// Local bus slave constants for page map, control offsets and timing dividers
`ifndef LB_DEFS_SVH
`define LB_DEFS_SVH

// Page numbers, taken from address bits 23 to 16
`define LB_PAGE_STATUS  8'h00
`define LB_PAGE_RXMAC   8'h03
`define LB_PAGE_CTRL    8'h05

// Offsets inside the control page
`define LB_REG_LED_USER 5'd1
`define LB_REG_LED1     5'd2
`define LB_REG_LED2     5'd3
`define LB_REG_HBANK    5'd5
`define LB_REG_MISC     5'd8
`define LB_REG_DAC      5'd9
// First of six 22-bit FMC test slices
`define LB_REG_FMC0     5'd16

// LED PWM counter width, one tick per wrap
`define LB_LED_CW       10
// Mirror RAM address width
`define LB_MIRROR_AW    5
// Clocks per DAC sclk half period
`define LB_DAC_TICK_DIV 4

// Read fill values
`define LB_UNMAPPED     32'hdeadbeef
`define LB_STATUS_FILL  "zzzz"

`endif

// ==== lb_pkg.sv ====
// Shared types for the local bus register slave
`include "lb_defs.svh"

package lb_pkg;

	// Plain vectors with a bus meaning
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;
	typedef logic [7:0]  page_t;
	typedef logic [4:0]  reg_sel_t;
	typedef logic [7:0]  duty_t;
	typedef logic [15:0] fault_cnt_t;

	// Registered write command, one clock after the strobe
	typedef struct packed {
		logic                       en;
		reg_sel_t                   sel;
		lb_data_t                   data;
		logic [`LB_MIRROR_AW-1:0]   addr;
	} lb_wr_t;

	// Read-only status sources
	typedef struct packed {
		fault_cnt_t  fault_count;
		logic [31:0] uptime;
		logic        tx_mac_done;
		logic [1:0]  rx_buf_status;
		logic        dac_busy;
	} status_t;

	// Control register outputs
	typedef struct packed {
		logic         led_user;
		duty_t        led1_duty;
		duty_t        led2_duty;
		logic         rx_mac_hbank;
		logic [3:0]   misc_config;
		logic [131:0] fmc_test;
	} cfg_t;

endpackage

// ==== lb_bus_ctrl.sv ====
// Local bus control: strobe decode, two-stage read pipeline and write command register
`timescale 1ns/10ps
`include "lb_defs.svh"

module lb_bus_ctrl
	import lb_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  lb_addr_t    addr,
	input  logic        control_strobe,
	input  logic        control_rd,
	input  lb_data_t    data_out,
	input  lb_data_t    status_word,
	input  lb_data_t    mirror_word,
	input  logic [15:0] rx_mac_data,
	output logic        rd_stb,
	output lb_wr_t      wr,
	output logic        dac_send,
	output lb_data_t    data_in
);

	logic  local_write;
	page_t page;
	page_t page_r;
	logic  rd_r;

	assign page = addr[23:16];

	// Read pulse goes straight to the first-stage banks
	assign rd_stb = control_strobe & control_rd;

	// Only the control page accepts writes
	assign local_write = control_strobe & ~control_rd & (page == `LB_PAGE_CTRL);

	// Stage 1: remember which page was asked for
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_r   <= 1'b0;
			page_r <= '0;
		end else begin
			rd_r   <= rd_stb;
			page_r <= page;
		end
	end

	// Stage 2: page mux, result held until the next read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_in <= '0;
		end else if (rd_r) begin
			case (page_r)
				`LB_PAGE_STATUS: data_in <= status_word;
				`LB_PAGE_RXMAC:  data_in <= {16'h0000, rx_mac_data};
				`LB_PAGE_CTRL:   data_in <= mirror_word;
				default:         data_in <= `LB_UNMAPPED;
			endcase
		end
	end

	// Write command and DAC send, both one clock after the strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr       <= '0;
			dac_send <= 1'b0;
		end else begin
			wr.en    <= local_write;
			wr.sel   <= reg_sel_t'(addr[4:0]);
			wr.data  <= data_out;
			wr.addr  <= addr[`LB_MIRROR_AW-1:0];
			// One-cycle send pulse for the DAC offset
			dac_send <= local_write & (addr[4:0] == `LB_REG_DAC);
		end
	end

endmodule

// ==== lb_status_bank.sv ====
// Status bank with fault and uptime counters and the first-stage status read mux
`timescale 1ns/10ps
`include "lb_defs.svh"

module lb_status_bank
	import lb_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rd_stb,
	input  logic [3:0] rd_sel,
	input  logic       xdomain_fault,
	input  logic       led_tick,
	input  logic       tx_mac_done,
	input  logic [1:0] rx_mac_buf_status,
	input  logic       dac_busy,
	output lb_data_t   status_word
);

	status_t st;

	// Counters and a single resync stage for the MAC and DAC status
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st <= '0;
		end else begin
			// Wraps at 16 bits, bursts expected at startup
			if (xdomain_fault)
				st.fault_count <= st.fault_count + 1'b1;
			// One count per LED counter wrap
			if (led_tick)
				st.uptime <= st.uptime + 1'b1;
			st.tx_mac_done   <= tx_mac_done;
			st.rx_buf_status <= rx_mac_buf_status;
			st.dac_busy      <= dac_busy;
		end
	end

	// First read stage, selected by the low four address bits
	always_ff @(posedge clk) begin
		if (rd_stb) begin
			case (rd_sel)
				4'h0:    status_word <= "Hell";
				4'h1:    status_word <= "o wo";
				4'h2:    status_word <= "rld!";
				4'h3:    status_word <= "(::)";
				4'h4:    status_word <= {16'h0000, st.fault_count};
				4'h6:    status_word <= {31'h0, st.tx_mac_done};
				4'h7:    status_word <= {30'h0, st.rx_buf_status};
				4'h8:    status_word <= st.uptime;
				4'ha:    status_word <= {31'h0, st.dac_busy};
				// Unused offsets read a recognisable filler
				default: status_word <= `LB_STATUS_FILL;
			endcase
		end
	end

endmodule

// ==== lb_ctrl_regs.sv ====
// Direct-write control registers for LEDs, misc bits, receive bank and FMC test pattern
`timescale 1ns/10ps
`include "lb_defs.svh"

module lb_ctrl_regs
	import lb_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  lb_wr_t wr,
	output cfg_t   cfg
);

	// Each FMC offset loads this many pattern bits
	localparam int FMC_SW = 22;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.led_user     <= 1'b0;
			cfg.led1_duty    <= '0;
			cfg.led2_duty    <= '0;
			// Receive side starts on the high bank
			cfg.rx_mac_hbank <= 1'b1;
			cfg.misc_config  <= 4'b0000;
			cfg.fmc_test     <= '0;
		end else if (wr.en) begin
			case (wr.sel)
				`LB_REG_LED_USER: cfg.led_user <= wr.data[0];
				`LB_REG_LED1:     cfg.led1_duty <= wr.data[7:0];
				`LB_REG_LED2:     cfg.led2_duty <= wr.data[7:0];
				`LB_REG_HBANK:    cfg.rx_mac_hbank <= wr.data[0];
				`LB_REG_MISC:     cfg.misc_config <= wr.data[3:0];
				// FMC pattern in six slices, lowest bits first
				`LB_REG_FMC0:
					cfg.fmc_test[0*FMC_SW +: FMC_SW] <= wr.data[FMC_SW-1:0];
				`LB_REG_FMC0 + 5'd1:
					cfg.fmc_test[1*FMC_SW +: FMC_SW] <= wr.data[FMC_SW-1:0];
				`LB_REG_FMC0 + 5'd2:
					cfg.fmc_test[2*FMC_SW +: FMC_SW] <= wr.data[FMC_SW-1:0];
				`LB_REG_FMC0 + 5'd3:
					cfg.fmc_test[3*FMC_SW +: FMC_SW] <= wr.data[FMC_SW-1:0];
				`LB_REG_FMC0 + 5'd4:
					cfg.fmc_test[4*FMC_SW +: FMC_SW] <= wr.data[FMC_SW-1:0];
				`LB_REG_FMC0 + 5'd5:
					cfg.fmc_test[5*FMC_SW +: FMC_SW] <= wr.data[FMC_SW-1:0];
				// DAC offset is handled by the send pulse
				default: ;
			endcase
		end
	end

endmodule

// ==== lb_mirror_ram.sv ====
// Mirror RAM that reads back every word written in the control page
`timescale 1ns/10ps
`include "lb_defs.svh"

module lb_mirror_ram
	import lb_pkg::*;
(
	input  logic                     clk,
	input  lb_wr_t                   wr,
	input  logic [`LB_MIRROR_AW-1:0] rd_addr,
	output lb_data_t                 mirror_word
);

	lb_data_t mem [0:(1<<`LB_MIRROR_AW)-1];

	// Write port, fed by the registered write command
	always_ff @(posedge clk) begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	// Read port samples every clock, same stage as the status bank
	always_ff @(posedge clk) begin
		mirror_word <= mem[rd_addr];
	end

endmodule

// ==== led_pwm.sv ====
// Two-channel LED PWM with a free-running counter and a wrap tick
`timescale 1ns/10ps
`include "lb_defs.svh"

module led_pwm
	import lb_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  duty_t led1_duty,
	input  duty_t led2_duty,
	output logic  led_tick,
	output logic  led1,
	output logic  led2
);

	logic [`LB_LED_CW-1:0] led_cc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_cc   <= '0;
			led_tick <= 1'b0;
			led1     <= 1'b0;
			led2     <= 1'b0;
		end else begin
			// Carry out of the counter is the tick
			{led_tick, led_cc} <= {1'b0, led_cc} + 1'b1;
			// Duty scaled by four against the full counter range
			led1 <= led_cc < {led1_duty, 2'b00};
			led2 <= led_cc < {led2_duty, 2'b00};
		end
	end

endmodule

// ==== dac_shifter.sv ====
// Serial frame shifter for a dual 16-bit DAC with per-channel sync and busy flag
`timescale 1ns/10ps
`include "lb_defs.svh"

module dac_shifter (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        send,
	input  logic [15:0] data,
	input  logic [1:0]  sel,
	output logic        busy,
	output logic        wr_dac_sclk,
	output logic        wr_dac_sdo,
	output logic [1:0]  wr_dac_sync
);

	typedef enum logic {
		DAC_IDLE,
		DAC_SHIFT
	} dac_state_t;

	localparam int FRAME_W = 24;

	dac_state_t  state;
	logic [1:0]  div;
	logic        tick;
	logic [23:0] frame;
	logic [4:0]  bit_cnt;

	// Half-period tick, counted only while shifting
	assign tick = (div == 2'(`LB_DAC_TICK_DIV - 1));
	assign busy = (state == DAC_SHIFT);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= DAC_IDLE;
			div         <= '0;
			frame       <= '0;
			bit_cnt     <= '0;
			wr_dac_sclk <= 1'b0;
			wr_dac_sdo  <= 1'b0;
			wr_dac_sync <= 2'b11;
		end else begin
			case (state)
				DAC_IDLE: begin
					div <= '0;
					// Sends while busy fall through and are dropped
					if (send) begin
						// Six spare bits, two power-down bits, then data MSB first
						frame       <= {6'b000000, 2'b00, data};
						bit_cnt     <= '0;
						wr_dac_sync <= ~sel;
						state       <= DAC_SHIFT;
					end
				end
				DAC_SHIFT: begin
					div <= div + 1'b1;
					if (tick) begin
						wr_dac_sclk <= ~wr_dac_sclk;
						if (!wr_dac_sclk) begin
							// Rising edge, present the next bit
							wr_dac_sdo <= frame[FRAME_W-1];
							frame      <= {frame[FRAME_W-2:0], 1'b0};
						end else if (bit_cnt == 5'(FRAME_W - 1)) begin
							// Last falling edge, release both channels
							wr_dac_sync <= 2'b11;
							state       <= DAC_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				default: state <= DAC_IDLE;
			endcase
		end
	end

endmodule

// ==== lb_slave_top.sv ====
// Local bus register slave top, bus control plus status, control, mirror, PWM and DAC blocks
`timescale 1ns/10ps
`include "lb_defs.svh"

module lb_slave_top
	import lb_pkg::*;
(
	input  logic         clk,
	input  logic         arst_n,
	// Host bus
	input  lb_addr_t     addr,
	input  logic         control_strobe,
	input  logic         control_rd,
	input  lb_data_t     data_out,
	output lb_data_t     data_in,
	// Status sources
	input  logic         xdomain_fault,
	input  logic         tx_mac_done,
	input  logic [15:0]  rx_mac_data,
	input  logic [1:0]   rx_mac_buf_status,
	// Configuration outputs
	output logic         rx_mac_hbank,
	output logic         cfg_d02,
	output logic         mmc_int,
	output logic         allow_mmc_eth_config,
	output logic         zest_pwr_en,
	// DAC serial port
	output logic         wr_dac_sclk,
	output logic         wr_dac_sdo,
	output logic [1:0]   wr_dac_sync,
	// Board outputs
	output logic [131:0] fmc_test,
	output logic         led_user_mode,
	output logic         led1,
	output logic         led2
);

	logic     rd_stb;
	lb_wr_t   wr;
	logic     dac_send;
	logic     dac_busy;
	logic     led_tick;
	lb_data_t status_word;
	lb_data_t mirror_word;
	cfg_t     cfg;

	lb_bus_ctrl u_bus_ctrl (
		.clk            (clk),
		.arst_n         (arst_n),
		.addr           (addr),
		.control_strobe (control_strobe),
		.control_rd     (control_rd),
		.data_out       (data_out),
		.status_word    (status_word),
		.mirror_word    (mirror_word),
		.rx_mac_data    (rx_mac_data),
		.rd_stb         (rd_stb),
		.wr             (wr),
		.dac_send       (dac_send),
		.data_in        (data_in)
	);

	lb_status_bank u_status_bank (
		.clk               (clk),
		.arst_n            (arst_n),
		.rd_stb            (rd_stb),
		.rd_sel            (addr[3:0]),
		.xdomain_fault     (xdomain_fault),
		.led_tick          (led_tick),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.dac_busy          (dac_busy),
		.status_word       (status_word)
	);

	lb_ctrl_regs u_ctrl_regs (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (wr),
		.cfg    (cfg)
	);

	// Read address taken straight from the bus, as for the status bank
	lb_mirror_ram u_mirror_ram (
		.clk         (clk),
		.wr          (wr),
		.rd_addr     (addr[`LB_MIRROR_AW-1:0]),
		.mirror_word (mirror_word)
	);

	led_pwm u_led_pwm (
		.clk       (clk),
		.arst_n    (arst_n),
		.led1_duty (cfg.led1_duty),
		.led2_duty (cfg.led2_duty),
		.led_tick  (led_tick),
		.led1      (led1),
		.led2      (led2)
	);

	// Channel selects ride in data bits 17 and 16
	dac_shifter u_dac_shifter (
		.clk         (clk),
		.arst_n      (arst_n),
		.send        (dac_send),
		.data        (wr.data[15:0]),
		.sel         (wr.data[17:16]),
		.busy        (dac_busy),
		.wr_dac_sclk (wr_dac_sclk),
		.wr_dac_sdo  (wr_dac_sdo),
		.wr_dac_sync (wr_dac_sync)
	);

	// Misc bits in board order
	assign cfg_d02              = cfg.misc_config[0];
	assign mmc_int              = cfg.misc_config[1];
	assign allow_mmc_eth_config = cfg.misc_config[2];
	assign zest_pwr_en          = cfg.misc_config[3];

	assign led_user_mode = cfg.led_user;
	assign rx_mac_hbank  = cfg.rx_mac_hbank;
	assign fmc_test      = cfg.fmc_test;

endmodule

// ==== tb_lb_slave.sv ====
// Directed testbench for the local bus register slave, bus tasks plus status, control and DAC tests
`timescale 1ns/10ps
`include "lb_defs.svh"

module tb_lb_slave
	import lb_pkg::*;
();

	logic         clk;
	logic         arst_n;
	lb_addr_t     addr;
	logic         control_strobe;
	logic         control_rd;
	lb_data_t     data_out;
	lb_data_t     data_in;
	logic         xdomain_fault;
	logic         tx_mac_done;
	logic [15:0]  rx_mac_data;
	logic [1:0]   rx_mac_buf_status;
	logic         rx_mac_hbank;
	logic         cfg_d02;
	logic         mmc_int;
	logic         allow_mmc_eth_config;
	logic         zest_pwr_en;
	logic         wr_dac_sclk;
	logic         wr_dac_sdo;
	logic [1:0]   wr_dac_sync;
	logic [131:0] fmc_test;
	logic         led_user_mode;
	logic         led1;
	logic         led2;

	integer       seed = 32'hd221;
	// DAC monitor state
	int           fall_cnt = 0;
	int           sync_errs = 0;
	logic [1:0]   sync_exp = 2'b11;
	logic [23:0]  dac_bits = '0;
	logic         sclk_q = 1'b0;

	lb_slave_top u_lb_slave_top (
		.clk                  (clk),
		.arst_n               (arst_n),
		.addr                 (addr),
		.control_strobe       (control_strobe),
		.control_rd           (control_rd),
		.data_out             (data_out),
		.data_in              (data_in),
		.xdomain_fault        (xdomain_fault),
		.tx_mac_done          (tx_mac_done),
		.rx_mac_data          (rx_mac_data),
		.rx_mac_buf_status    (rx_mac_buf_status),
		.rx_mac_hbank         (rx_mac_hbank),
		.cfg_d02              (cfg_d02),
		.mmc_int              (mmc_int),
		.allow_mmc_eth_config (allow_mmc_eth_config),
		.zest_pwr_en          (zest_pwr_en),
		.wr_dac_sclk          (wr_dac_sclk),
		.wr_dac_sdo           (wr_dac_sdo),
		.wr_dac_sync          (wr_dac_sync),
		.fmc_test             (fmc_test),
		.led_user_mode        (led_user_mode),
		.led1                 (led1),
		.led2                 (led2)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Falling sclk seen on the clock's falling edge, sdo is stable there
	always @(negedge clk) begin
		if (sclk_q === 1'b1 && wr_dac_sclk === 1'b0) begin
			// Sync is released together with the last fall
			if (fall_cnt < 23 && wr_dac_sync !== sync_exp)
				sync_errs = sync_errs + 1;
			dac_bits = {dac_bits[22:0], wr_dac_sdo};
			fall_cnt = fall_cnt + 1;
		end
		sclk_q = wr_dac_sclk;
	end

	function automatic lb_addr_t bus_addr(input page_t page, input logic [4:0] off);
		bus_addr = {page, 11'h000, off};
	endfunction

	task automatic check(input string name, input logic [131:0] act, input logic [131:0] exp);
		if (act !== exp) begin
			$display("Error: %s is %h, expected %h", name, act, exp);
			$display("** FAIL **");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("** FAIL **");
		$fatal(1, "Wait limit reached");
	endtask

	// Called on a falling edge, returns once the registers have taken the write
	task automatic lb_write(input lb_addr_t a, input lb_data_t d);
		addr           = a;
		data_out       = d;
		control_rd     = 1'b0;
		control_strobe = 1'b1;
		@(negedge clk);
		control_strobe = 1'b0;
		@(negedge clk);
	endtask

	// data_in is valid after the second rising edge following the strobe
	task automatic lb_read(input lb_addr_t a, output lb_data_t d);
		addr           = a;
		control_rd     = 1'b1;
		control_strobe = 1'b1;
		@(negedge clk);
		control_strobe = 1'b0;
		control_rd     = 1'b0;
		@(negedge clk);
		d = data_in;
	endtask

	task automatic read_and_check(input string name, input lb_addr_t a, input lb_data_t exp);
		lb_data_t d;
		lb_read(a, d);
		check(name, d, exp);
	endtask

	// Poll the busy flag at status offset 10
	task automatic wait_dac_idle();
		lb_data_t d;
		int n;
		n = 0;
		lb_read(bus_addr(`LB_PAGE_STATUS, 5'd10), d);
		while (d[0] !== 1'b0) begin
			n++;
			if (n > 200)
				report_timeout("DAC busy to clear");
			else
				lb_read(bus_addr(`LB_PAGE_STATUS, 5'd10), d);
		end
	endtask

	task automatic count_led_high(output int c1, output int c2);
		int i;
		c1 = 0;
		c2 = 0;
		for (i = 0; i < 1024; i++) begin
			@(negedge clk);
			c1 = c1 + int'(led1);
			c2 = c2 + int'(led2);
		end
	endtask

	task automatic reset_values();
		check("led1", led1, 0);
		check("led2", led2, 0);
		check("led_user_mode", led_user_mode, 0);
		check("misc", {zest_pwr_en, allow_mmc_eth_config, mmc_int, cfg_d02}, 0);
		check("fmc_test", fmc_test, 0);
		check("rx_mac_hbank", rx_mac_hbank, 1);
		check("wr_dac_sync", wr_dac_sync, 2'b11);
		check("wr_dac_sclk", wr_dac_sclk, 0);
		check("data_in", data_in, 0);
		// ID string, filler and an unmapped page
		read_and_check("status 0", bus_addr(`LB_PAGE_STATUS, 5'd0), "Hell");
		read_and_check("status 1", bus_addr(`LB_PAGE_STATUS, 5'd1), "o wo");
		read_and_check("status 2", bus_addr(`LB_PAGE_STATUS, 5'd2), "rld!");
		read_and_check("status 3", bus_addr(`LB_PAGE_STATUS, 5'd3), "(::)");
		read_and_check("status 5", bus_addr(`LB_PAGE_STATUS, 5'd5), "zzzz");
		read_and_check("dac_busy", bus_addr(`LB_PAGE_STATUS, 5'd10), 0);
		read_and_check("page 2", bus_addr(8'h02, 5'd0), 32'hdeadbeef);
	endtask

	task automatic control_writes();
		lb_data_t d;
		logic [131:0] fmc_exp;
		int i;
		// Written bits differ from the reset values
		d = $random(seed);
		d[0] = 1'b1;
		lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_LED_USER), d);
		check("led_user_mode", led_user_mode, d[0]);
		d = $random(seed);
		d[0] = 1'b0;
		lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_HBANK), d);
		check("rx_mac_hbank", rx_mac_hbank, d[0]);
		d = $random(seed);
		if (d[3:0] == 4'h0)
			d[3:0] = 4'ha;
		lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_MISC), d);
		check("misc", {zest_pwr_en, allow_mmc_eth_config, mmc_int, cfg_d02}, d[3:0]);
		// Six 22-bit slices, lowest first
		fmc_exp = '0;
		for (i = 0; i < 6; i++) begin
			d = $random(seed);
			fmc_exp[i*22 +: 22] = d[21:0];
			lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_FMC0 + 5'(i)), d);
		end
		check("fmc_test", fmc_test, fmc_exp);
		d = $random(seed);
		rx_mac_data = d[15:0];
		@(negedge clk);
		read_and_check("rx_mac_data", bus_addr(`LB_PAGE_RXMAC, 5'd0), {16'h0000, d[15:0]});
	endtask

	task automatic mirror_readback();
		lb_data_t words [32];
		lb_data_t d;
		int i;
		for (i = 0; i < 32; i++) begin
			words[i] = $random(seed);
			lb_write(bus_addr(`LB_PAGE_CTRL, 5'(i)), words[i]);
		end
		for (i = 0; i < 32; i++) begin
			lb_read(bus_addr(`LB_PAGE_CTRL, 5'(i)), d);
			check($sformatf("mirror word %0d", i), d, words[i]);
		end
	endtask

	task automatic status_counters();
		lb_data_t u0;
		lb_data_t u1;
		lb_data_t d;
		int n;
		int i;
		n = ($random(seed) & 15) + 1;
		// One-clock fault pulses with random gaps
		for (i = 0; i < n; i++) begin
			xdomain_fault = 1'b1;
			@(negedge clk);
			xdomain_fault = 1'b0;
			repeat (1 + ($random(seed) & 3)) @(negedge clk);
		end
		repeat (2) @(negedge clk);
		read_and_check("fault_count", bus_addr(`LB_PAGE_STATUS, 5'd4), n);
		// Uptime ticks once per 1024 clocks
		lb_read(bus_addr(`LB_PAGE_STATUS, 5'd8), u0);
		repeat (2100) @(negedge clk);
		lb_read(bus_addr(`LB_PAGE_STATUS, 5'd8), u1);
		check("uptime increase at least 2", (u1 - u0) >= 2, 1);
		d = $random(seed);
		// Nonzero so the read differs from the reset value
		if (d[1:0] == 2'b00)
			d[1:0] = 2'b10;
		tx_mac_done = 1'b1;
		rx_mac_buf_status = d[1:0];
		repeat (2) @(negedge clk);
		read_and_check("tx_mac_done", bus_addr(`LB_PAGE_STATUS, 5'd6), 1);
		read_and_check("rx_buf_status", bus_addr(`LB_PAGE_STATUS, 5'd7), {30'h0, d[1:0]});
	endtask

	task automatic led_duty();
		duty_t d1;
		duty_t d2;
		int c1;
		int c2;
		int k;
		for (k = 0; k < 4; k++) begin
			d1 = $random(seed);
			d2 = $random(seed);
			// Last pass checks that a zero duty keeps both LEDs dark
			if (k == 3) begin
				d1 = '0;
				d2 = '0;
			end
			lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_LED1), {24'h0, d1});
			lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_LED2), {24'h0, d2});
			repeat (3) @(negedge clk);
			count_led_high(c1, c2);
			check("led1 high count", c1, 4 * int'(d1));
			check("led2 high count", c2, 4 * int'(d2));
		end
	endtask

	task automatic dac_frames();
		lb_data_t d;
		lb_data_t rd;
		logic [1:0] sel;
		int k;
		for (k = 1; k <= 3; k++) begin
			wait_dac_idle();
			sel = 2'(k);
			d = $random(seed);
			sync_exp = ~sel;
			fall_cnt = 0;
			sync_errs = 0;
			lb_write(bus_addr(`LB_PAGE_CTRL, `LB_REG_DAC), {14'h0000, sel, d[15:0]});
			// Busy reaches the status bank one clock later
			@(negedge clk);
			lb_read(bus_addr(`LB_PAGE_STATUS, 5'd10), rd);
			check("dac_busy", rd, 1);
			check("wr_dac_sync", wr_dac_sync, sync_exp);
			wait_dac_idle();
			check("dac bit count", fall_cnt, 24);
			check("dac frame", dac_bits, {8'h00, d[15:0]});
			check("wr_dac_sync errors in frame", sync_errs, 0);
			check("wr_dac_sync", wr_dac_sync, 2'b11);
		end
	endtask

	initial begin
		arst_n            = 1'b0;
		addr              = '0;
		control_strobe    = 1'b0;
		control_rd        = 1'b0;
		data_out          = '0;
		xdomain_fault     = 1'b0;
		tx_mac_done       = 1'b0;
		rx_mac_data       = '0;
		rx_mac_buf_status = '0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		reset_values();
		control_writes();
		mirror_readback();
		status_counters();
		led_duty();
		dac_frames();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
lb_pkg.sv
lb_bus_ctrl.sv
lb_status_bank.sv
lb_ctrl_regs.sv
lb_mirror_ram.sv
led_pwm.sv
dac_shifter.sv
lb_slave_top.sv
tb_lb_slave.sv

// ==== Makefile ====
# Verilator build and run for the local bus slave testbench

VERILATOR ?= verilator
TOP       ?= tb_lb_slave
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
